// File: design/fb_config.svh
/*
 build-time constants for the frame buffer
 frame size is in bytes and must stay below 2^24 (24-bit dma byte count)
 register offsets decode on paddr[7:0] only, so the map repeats every 256 bytes
*/
`ifndef FB_CONFIG_SVH
`define FB_CONFIG_SVH

`define FB_FRAME_SIZE 24'h000400 // small frame keeps sim short
`define FB_MAX_SLOTS 4'd8 // ring depth limit, n_sub1 is 3 bits

// apb register byte offsets
`define FB_REG_CTRL 8'h00 // [0] enable, [1] post-processing
`define FB_REG_BASE 8'h04 // ring base address
`define FB_REG_NSUB1 8'h08 // slot count - 1
`define FB_REG_PROC 8'h0C // write 1 to [0] -> frame processed
`define FB_REG_IRQ_STS 8'h10 // [0] write done, [1] read done, w1c
`define FB_REG_IRQ_EN 8'h14 // same bit layout as status
`define FB_REG_OCC 8'h18 // occupied slots, read only

`endif

// File: design/fb_pkg.sv
/*
 shared types of the frame buffer controller
 dma_cmd_t layout is {byte count, start address}, same as the dma engine expects
*/
`default_nettype none

package fb_pkg;

	typedef logic [31:0] addr_t; // byte address / apb word
	typedef logic [23:0] byte_cnt_t; // dma transfer length
	typedef logic [2:0] slot_t; // slot index, up to 8 slots
	typedef logic [3:0] occ_t; // 0..8 occupied slots
	typedef logic [55:0] dma_cmd_t; // [55:32] bytes, [31:0] addr

	// one per dma channel
	typedef enum logic {
		chan_idle, // no command out
		chan_busy // command issued, waiting for done
	} chan_state_e;

endpackage

`default_nettype wire

// File: design/fb_ifs.sv
/*
 internal buses of the frame buffer
 filled, fetched, processed, wr_req and rd_req are single-cycle pulses
*/
`timescale 1ns/1ps
`default_nettype none

// register block <-> slot controller, base also seen by the command issuer
interface fb_cfg_if;
	logic enable;
	logic pos_proc_en; // hold frames until software marks them
	fb_pkg::addr_t base_addr;
	fb_pkg::slot_t n_sub1;
	logic processed; // pulse from PROC write
	logic filled; // pulse, s2mm frame done
	logic fetched; // pulse, mm2s frame done
	fb_pkg::occ_t occupancy;

	modport reg_side (output enable, pos_proc_en, base_addr, n_sub1, processed,
		input filled, fetched, occupancy);
	modport ctrl_side (input enable, pos_proc_en, n_sub1, processed,
		output filled, fetched, occupancy);
	modport cfg_view (input base_addr);
endinterface

// slot controller -> command issuer
interface fb_cmd_if;
	logic wr_req, rd_req; // request pulses
	fb_pkg::slot_t wr_slot, rd_slot; // stable while requesting
	logic wr_busy, rd_busy; // request seen, handshake not done yet

	modport ctrl_side (output wr_req, rd_req, wr_slot, rd_slot, input wr_busy, rd_busy);
	modport issue_side (input wr_req, rd_req, wr_slot, rd_slot, output wr_busy, rd_busy);
endinterface

`default_nettype wire

// File: design/fb_reg_decode.sv
/*
 apb slave, zero wait states, never errors
 decode uses paddr[7:0], PROC reads back 0
 irq status bits set on filled/fetched and clear on write-1, set wins over clear
*/
`timescale 1ns/1ps
`default_nettype none
`include "fb_config.svh"

module fb_reg_decode (
	input logic clk,
	input logic reset,
	input fb_pkg::addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input fb_pkg::addr_t pwdata,
	output logic pready,
	output fb_pkg::addr_t prdata,
	output logic pslverr,
	fb_cfg_if.reg_side cfg,
	output logic frame_wt_itr_req,
	output logic frame_rd_itr_req
);

	logic [7:0] offs;
	logic wr_acc, rd_acc; // access phase qualifiers
	logic [1:0] ctrl_q; // {pos_proc_en, enable}
	fb_pkg::addr_t base_q;
	fb_pkg::slot_t nsub1_q;
	logic proc_q; // processed pulse
	logic [1:0] irq_sts_q, irq_en_q; // [0] write, [1] read
	logic [1:0] sts_clr;

	assign offs = paddr[7:0];
	assign wr_acc = psel & penable & pwrite;
	assign rd_acc = psel & penable & ~pwrite;
	assign sts_clr = (wr_acc && offs == `FB_REG_IRQ_STS) ? pwdata[1:0] : 2'b00;

	assign pready = 1'b1;
	assign pslverr = 1'b0;

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_q <= 2'b00;
			base_q <= '0;
			nsub1_q <= '0;
			proc_q <= 1'b0;
			irq_sts_q <= 2'b00;
			irq_en_q <= 2'b00;
		end else begin
			proc_q <= wr_acc && offs == `FB_REG_PROC && pwdata[0]; // fires next cycle
			irq_sts_q <= (irq_sts_q & ~sts_clr) | {cfg.fetched, cfg.filled};
			if (wr_acc) begin
				case (offs)
					`FB_REG_CTRL: ctrl_q <= pwdata[1:0];
					`FB_REG_BASE: base_q <= pwdata;
					`FB_REG_NSUB1: nsub1_q <= pwdata[2:0];
					`FB_REG_IRQ_EN: irq_en_q <= pwdata[1:0];
					default: ; // PROC/IRQ_STS handled above, OCC is read only
				endcase
			end
		end
	end

	// read mux, only drives data in the access phase
	always_comb begin
		prdata = '0;
		if (rd_acc) begin
			case (offs)
				`FB_REG_CTRL: prdata = {30'd0, ctrl_q};
				`FB_REG_BASE: prdata = base_q;
				`FB_REG_NSUB1: prdata = {29'd0, nsub1_q};
				`FB_REG_IRQ_STS: prdata = {30'd0, irq_sts_q};
				`FB_REG_IRQ_EN: prdata = {30'd0, irq_en_q};
				`FB_REG_OCC: prdata = {28'd0, cfg.occupancy};
				default: prdata = '0;
			endcase
		end
	end

	assign cfg.enable = ctrl_q[0];
	assign cfg.pos_proc_en = ctrl_q[1];
	assign cfg.base_addr = base_q;
	assign cfg.n_sub1 = nsub1_q;
	assign cfg.processed = proc_q;

	assign frame_wt_itr_req = irq_sts_q[0] & irq_en_q[0];
	assign frame_rd_itr_req = irq_sts_q[1] & irq_en_q[1];

	// apb master must select before enabling
	a_penable_psel: assert property (@(posedge clk) disable iff (reset)
		penable |-> psel);

endmodule

`default_nettype wire

// File: design/fb_slot_ctrl.sv
/*
 slot ring bookkeeping, index 0 is the write (s2mm) channel, 1 the read (mm2s) channel
 one command outstanding per channel; pointers advance when the frame completes
 clearing enable flushes pointers and counts once both channels are idle
*/
`timescale 1ns/1ps
`default_nettype none
`include "fb_config.svh"

module fb_slot_ctrl (
	input logic clk,
	input logic reset,
	fb_cfg_if.ctrl_side cfg,
	fb_cmd_if.ctrl_side cmd,
	input logic s2mm_done,
	input logic mm2s_done
);

	fb_pkg::chan_state_e state [2];
	fb_pkg::slot_t ptr [2]; // next slot per channel
	logic [1:0] done, busy, can_go;
	logic [1:0] req_q; // request pulses
	logic [1:0] ev_q; // filled / fetched pulses
	fb_pkg::occ_t occ_q, rdbl_q; // occupied, ready to read
	fb_pkg::occ_t occ_nxt, rdbl_nxt;
	fb_pkg::occ_t cap; // slots in the ring
	logic flush;

	assign done = {mm2s_done, s2mm_done};
	assign busy = {cmd.rd_busy, cmd.wr_busy};
	assign cap = {1'b0, cfg.n_sub1} + 4'd1;
	assign flush = !cfg.enable && state[0] == fb_pkg::chan_idle
		&& state[1] == fb_pkg::chan_idle;

	// room to write / something to read
	assign can_go[0] = cfg.enable && occ_q < cap && state[0] == fb_pkg::chan_idle && !busy[0];
	assign can_go[1] = cfg.enable && rdbl_q != '0 && state[1] == fb_pkg::chan_idle && !busy[1];

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (reset) begin
				state[i] <= fb_pkg::chan_idle;
				req_q[i] <= 1'b0;
				ev_q[i] <= 1'b0;
				ptr[i] <= '0;
			end else begin
				req_q[i] <= 1'b0;
				ev_q[i] <= done[i]; // one cycle behind the dma
				case (state[i])
					fb_pkg::chan_idle: if (can_go[i]) begin
						req_q[i] <= 1'b1;
						state[i] <= fb_pkg::chan_busy;
					end
					fb_pkg::chan_busy: if (ev_q[i]) state[i] <= fb_pkg::chan_idle; // counts update now too
					default: state[i] <= fb_pkg::chan_idle;
				endcase
				if (flush)
					ptr[i] <= '0;
				else if (ev_q[i])
					ptr[i] <= (ptr[i] >= cfg.n_sub1) ? '0 : ptr[i] + 3'd1; // wrap at n_sub1
			end
		end
	end

	// occupancy and readable count
	always_comb begin
		occ_nxt = occ_q;
		if (ev_q[0])
			occ_nxt = occ_nxt + 4'd1;
		if (ev_q[1])
			occ_nxt = occ_nxt - 4'd1;
		rdbl_nxt = rdbl_q;
		if (ev_q[1])
			rdbl_nxt = rdbl_nxt - 4'd1;
		if (!cfg.pos_proc_en)
			rdbl_nxt = occ_nxt; // every filled frame is readable
		else if (cfg.processed && rdbl_q < occ_q)
			rdbl_nxt = rdbl_nxt + 4'd1; // release one held frame
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			occ_q <= '0;
			rdbl_q <= '0;
		end else begin
			occ_q <= occ_nxt;
			rdbl_q <= rdbl_nxt;
		end
	end

	assign cmd.wr_req = req_q[0];
	assign cmd.rd_req = req_q[1];
	assign cmd.wr_slot = ptr[0];
	assign cmd.rd_slot = ptr[1];
	assign cfg.filled = ev_q[0];
	assign cfg.fetched = ev_q[1];
	assign cfg.occupancy = occ_q;

	a_occ_bound: assert property (@(posedge clk) disable iff (reset)
		occ_q <= cap && occ_q <= `FB_MAX_SLOTS);

	// dma must only finish what was issued
	for (genvar g = 0; g < 2; g++) begin : g_done_chk
		a_done_busy: assert property (@(posedge clk) disable iff (reset)
			done[g] |-> state[g] == fb_pkg::chan_busy);
	end

endmodule

`default_nettype wire

// File: design/fb_cmd_issue.sv
/*
 dma command issuer, index 0 s2mm, 1 mm2s
 command word is captured on the request and held until valid & ready
 base_addr is sampled at request time, later writes do not touch a pending command
*/
`timescale 1ns/1ps
`default_nettype none
`include "fb_config.svh"

module fb_cmd_issue (
	input logic clk,
	input logic reset,
	fb_cmd_if.issue_side cmd,
	fb_cfg_if.cfg_view cfg,
	output fb_pkg::dma_cmd_t s2mm_cmd_data,
	output logic s2mm_cmd_valid,
	input logic s2mm_cmd_ready,
	output fb_pkg::dma_cmd_t mm2s_cmd_data,
	output logic mm2s_cmd_valid,
	input logic mm2s_cmd_ready
);

	logic [1:0] req, rdy, vld_q;
	fb_pkg::slot_t slot [2];
	fb_pkg::dma_cmd_t data_q [2];

	// {frame bytes, base + slot * frame bytes}
	function automatic fb_pkg::dma_cmd_t form_cmd(input fb_pkg::addr_t base,
		input fb_pkg::slot_t s);
		fb_pkg::addr_t offs;
		offs = fb_pkg::addr_t'(s) * fb_pkg::addr_t'(`FB_FRAME_SIZE);
		return {fb_pkg::byte_cnt_t'(`FB_FRAME_SIZE), base + offs};
	endfunction

	assign req = {cmd.rd_req, cmd.wr_req};
	assign rdy = {mm2s_cmd_ready, s2mm_cmd_ready};
	assign slot[0] = cmd.wr_slot;
	assign slot[1] = cmd.rd_slot;

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (reset)
				vld_q[i] <= 1'b0;
			else if (vld_q[i] && rdy[i])
				vld_q[i] <= 1'b0; // handshake done
			else if (req[i])
				vld_q[i] <= 1'b1;
		end
	end

	// payload, only loads when nothing is pending
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (req[i] && !vld_q[i])
				data_q[i] <= form_cmd(cfg.base_addr, slot[i]);
		end
	end

	assign s2mm_cmd_data = data_q[0];
	assign s2mm_cmd_valid = vld_q[0];
	assign mm2s_cmd_data = data_q[1];
	assign mm2s_cmd_valid = vld_q[1];

	assign cmd.wr_busy = req[0] | vld_q[0]; // covers the request cycle
	assign cmd.rd_busy = req[1] | vld_q[1];

	// a request while a command still waits would be lost
	for (genvar g = 0; g < 2; g++) begin : g_req_chk
		a_req_pending: assert property (@(posedge clk) disable iff (reset)
			req[g] |-> !vld_q[g]);
	end

endmodule

`default_nettype wire

// File: design/frame_buffer_top.sv
/*
 frame buffer controller top, single clock domain, sync active-high reset
 dma done inputs are one-cycle pulses, one command in flight per channel
*/
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_top (
	input logic clk,
	input logic reset,
	// apb slave
	input fb_pkg::addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input fb_pkg::addr_t pwdata,
	output logic pready, // tied 1
	output fb_pkg::addr_t prdata,
	output logic pslverr, // tied 0
	// dma commands
	output fb_pkg::dma_cmd_t s2mm_cmd_data,
	output logic s2mm_cmd_valid,
	input logic s2mm_cmd_ready,
	output fb_pkg::dma_cmd_t mm2s_cmd_data,
	output logic mm2s_cmd_valid,
	input logic mm2s_cmd_ready,
	input logic s2mm_done,
	input logic mm2s_done,
	// status
	output logic frame_filled,
	output logic frame_fetched,
	output logic frame_wt_itr_req,
	output logic frame_rd_itr_req
);

	fb_cfg_if cfg_bus ();
	fb_cmd_if cmd_bus ();

	fb_reg_decode u_decode (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr),
		.cfg(cfg_bus.reg_side),
		.frame_wt_itr_req(frame_wt_itr_req),
		.frame_rd_itr_req(frame_rd_itr_req)
	);

	fb_slot_ctrl u_execute (
		.clk(clk),
		.reset(reset),
		.cfg(cfg_bus.ctrl_side),
		.cmd(cmd_bus.ctrl_side),
		.s2mm_done(s2mm_done),
		.mm2s_done(mm2s_done)
	);

	fb_cmd_issue u_result (
		.clk(clk),
		.reset(reset),
		.cmd(cmd_bus.issue_side),
		.cfg(cfg_bus.cfg_view),
		.s2mm_cmd_data(s2mm_cmd_data),
		.s2mm_cmd_valid(s2mm_cmd_valid),
		.s2mm_cmd_ready(s2mm_cmd_ready),
		.mm2s_cmd_data(mm2s_cmd_data),
		.mm2s_cmd_valid(mm2s_cmd_valid),
		.mm2s_cmd_ready(mm2s_cmd_ready)
	);

	assign frame_filled = cfg_bus.filled; // pulse, cycle after s2mm_done
	assign frame_fetched = cfg_bus.fetched;

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
/*
 testbench clock, 10 ns period, reset high for the first 10 rising edges
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk) reset = 1'b0; // released away from the sampling edge
	end

endmodule

`default_nettype wire

// File: tests/tb_frame_buffer.sv
/*
 testbench for frame_buffer_top, models a dma engine on both command ports
 one command in flight per channel, done after a random 0..7 cycle delay
 inputs change on the falling edge, outputs sampled on the rising edge
*/
`timescale 1ns/1ps
`default_nettype none
`include "fb_config.svh"

module tb_frame_buffer;

	logic clk, reset;
	fb_pkg::addr_t paddr, pwdata, prdata;
	logic psel, penable, pwrite, pready, pslverr;
	fb_pkg::dma_cmd_t dat [2];
	logic vld [2];
	logic rdy [2], done [2];
	logic filled, fetched, wt_irq, rd_irq;

	logic [31:0] lfsr;
	logic hold [2]; // force ready low
	logic stall; // random ready
	logic out [2], start [2], held [2];
	int cnt [2]; // done countdown, -1 when idle
	fb_pkg::dma_cmd_t held_data [2];
	fb_pkg::dma_cmd_t s2mm_log [$];
	fb_pkg::dma_cmd_t mm2s_log [$];
	int filled_cnt, fetched_cnt, errors, t, k, s0, m0;
	fb_pkg::addr_t ring_base;

	tb_clock_gen u_clk (.clk(clk), .reset(reset));

	frame_buffer_top uut (
		.clk(clk), .reset(reset),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .pready(pready), .prdata(prdata), .pslverr(pslverr),
		.s2mm_cmd_data(dat[0]), .s2mm_cmd_valid(vld[0]), .s2mm_cmd_ready(rdy[0]),
		.mm2s_cmd_data(dat[1]), .mm2s_cmd_valid(vld[1]), .mm2s_cmd_ready(rdy[1]),
		.s2mm_done(done[0]), .mm2s_done(done[1]),
		.frame_filled(filled), .frame_fetched(fetched),
		.frame_wt_itr_req(wt_irq), .frame_rd_itr_req(rd_irq)
	);

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	// expected command word for a ring slot
	function automatic fb_pkg::dma_cmd_t exp_cmd(input fb_pkg::addr_t base, input int slot);
		return {24'(`FB_FRAME_SIZE), base + 32'(slot) * 32'(`FB_FRAME_SIZE)};
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("error %s: expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		$display("%0d errors, run aborted", errors);
		$display("Some tests failed");
		$finish;
	endtask

	// one cycle of a bounded wait
	task automatic tick(inout int n, input string what);
		@(negedge clk);
		n++;
		if (n > 5000)
			timed_out(what);
	endtask

	task automatic apb_write(input logic [7:0] addr, input fb_pkg::addr_t data);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = 32'(addr);
		pwdata = data;
		@(negedge clk) penable = 1'b1; // access phase
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read_check(input string name, input logic [7:0] addr,
		input fb_pkg::addr_t exp);
		fb_pkg::addr_t got;
		logic [1:0] resp; // {pready, pslverr}
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = 32'(addr);
		@(negedge clk) penable = 1'b1;
		@(posedge clk);
		got = prdata;
		resp = {pready, pslverr};
		check(name, 64'(exp), 64'(got));
		check({name, "_resp"}, 64'(2'b10), 64'(resp)); // ready, no slave error
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// wait until both channels stay quiet for a few cycles
	task automatic drain();
		int n, quiet;
		n = 0;
		quiet = 0;
		while (quiet < 4) begin
			tick(n, "dma drain");
			quiet = (!vld[0] && !vld[1] && !out[0] && !out[1]) ? quiet + 1 : 0;
		end
	endtask

	// dma side: record transfers, check hold rule and command count
	always @(posedge clk) begin
		for (int c = 0; c < 2; c++) begin
			if (!reset && held[c] && vld[c] && dat[c] !== held_data[c]) begin
				$display("error backpressure: expected %h actual %h", held_data[c], dat[c]);
				errors++;
			end
			if (!reset && held[c] && !vld[c]) begin
				$display("channel %0d dropped valid before the transfer", c);
				errors++;
			end
			held[c] = vld[c] && !rdy[c];
			held_data[c] = dat[c];
			if (!reset && vld[c] && rdy[c]) begin
				if (out[c]) begin
					$display("channel %0d sent a second command before done", c);
					errors++;
				end
				if (c == 0)
					s2mm_log.push_back(dat[c]);
				else
					mm2s_log.push_back(dat[c]);
				out[c] = 1'b1;
				start[c] = 1'b1;
			end
		end
		if (filled)
			filled_cnt++;
		if (fetched)
			fetched_cnt++;
	end

	always @(negedge clk) begin
		for (int c = 0; c < 2; c++) begin
			done[c] = 1'b0;
			if (start[c]) begin
				start[c] = 1'b0;
				cnt[c] = int'(rand_bits(3)); // latency of this frame
			end else if (cnt[c] == 0) begin
				done[c] = 1'b1;
				cnt[c] = -1;
				out[c] = 1'b0;
			end else if (cnt[c] > 0)
				cnt[c]--;
			rdy[c] = hold[c] ? 1'b0 : (stall ? (rand_bits(1) != 0) : 1'b1);
		end
	end

	task automatic test_regs();
		apb_read_check("reset_ctrl", `FB_REG_CTRL, 0);
		apb_read_check("reset_base", `FB_REG_BASE, 0);
		apb_read_check("reset_nsub1", `FB_REG_NSUB1, 0);
		apb_read_check("reset_proc", `FB_REG_PROC, 0);
		apb_read_check("reset_sts", `FB_REG_IRQ_STS, 0);
		apb_read_check("reset_en", `FB_REG_IRQ_EN, 0);
		apb_read_check("reset_occ", `FB_REG_OCC, 0);
		apb_write(`FB_REG_CTRL, 32'hffff_fffe); // post-proc only, still disabled
		apb_read_check("ctrl_mask", `FB_REG_CTRL, 32'h2);
		apb_write(`FB_REG_BASE, 32'h1234_5678);
		apb_read_check("base_rb", `FB_REG_BASE, 32'h1234_5678);
		apb_write(`FB_REG_NSUB1, 32'hff);
		apb_read_check("nsub1_mask", `FB_REG_NSUB1, 32'h7);
		apb_write(`FB_REG_IRQ_EN, 32'hff);
		apb_read_check("irq_en_mask", `FB_REG_IRQ_EN, 32'h3);
		apb_write(`FB_REG_IRQ_EN, 0);
		apb_write(`FB_REG_CTRL, 0);
	endtask

	task automatic test_write_ring();
		ring_base = 32'h8000_0000;
		apb_write(`FB_REG_BASE, ring_base);
		apb_write(`FB_REG_NSUB1, 3);
		apb_write(`FB_REG_CTRL, 3); // enabled, frames held
		t = 0;
		while (s2mm_log.size() < 4)
			tick(t, "four s2mm commands");
		repeat (60) @(negedge clk); // ring full, nothing more may come
		check("write_ring_count", 4, 64'(s2mm_log.size()));
		check("write_ring_reads", 0, 64'(mm2s_log.size()));
		for (int i = 0; i < 4; i++)
			check("write_ring_addr", 64'(exp_cmd(ring_base, i)), 64'(s2mm_log[i]));
		apb_read_check("write_ring_occ", `FB_REG_OCC, 4);
	endtask

	task automatic test_proc_gate();
		for (k = 0; k < 4; k++) begin
			apb_write(`FB_REG_PROC, 1);
			t = 0;
			while (fetched_cnt < k + 1)
				tick(t, "fetched pulse");
			check("proc_one_read", 64'(k + 1), 64'(mm2s_log.size()));
			check("proc_read_addr", 64'(exp_cmd(ring_base, k)), 64'(mm2s_log[k]));
			t = 0;
			while (s2mm_log.size() < 5 + k)
				tick(t, "reuse of a freed slot");
			check("proc_wrap_addr", 64'(exp_cmd(ring_base, k)), 64'(s2mm_log[4 + k]));
		end
	endtask

	task automatic test_pass_through();
		hold[0] = 1'b1; // stop writes so reads can catch up
		apb_write(`FB_REG_CTRL, 1);
		t = 0;
		while (fetched_cnt != filled_cnt)
			tick(t, "reads to catch up with writes");
		apb_read_check("pass_occ", `FB_REG_OCC, 0);
		check("pass_reads", 8, 64'(mm2s_log.size()));
		hold[0] = 1'b0; // new frames now go straight to the read side
		t = 0;
		while (mm2s_log.size() < 12)
			tick(t, "reads of pass-through frames");
		apb_write(`FB_REG_CTRL, 0);
		drain();
		// ring of 4, so frame i lives in slot i mod 4 on both sides
		for (int i = 0; i < 12; i++) begin
			check("pass_write_slot", 64'(exp_cmd(ring_base, i % 4)), 64'(s2mm_log[i]));
			check("pass_same_slot", 64'(exp_cmd(ring_base, i % 4)), 64'(mm2s_log[i]));
		end
	endtask

	task automatic test_irq();
		hold[0] = 1'b1;
		hold[1] = 1'b1;
		apb_write(`FB_REG_NSUB1, 0); // single slot
		apb_write(`FB_REG_IRQ_STS, 3);
		apb_write(`FB_REG_IRQ_EN, 3);
		apb_write(`FB_REG_CTRL, 1);
		check("irq_idle_wt", 0, 64'(wt_irq));
		check("irq_idle_rd", 0, 64'(rd_irq));
		hold[0] = 1'b0;
		t = 0;
		while (!wt_irq)
			tick(t, "write interrupt");
		check("irq_rd_quiet", 0, 64'(rd_irq));
		apb_write(`FB_REG_IRQ_STS, 1);
		check("irq_wt_clear", 0, 64'(wt_irq));
		apb_write(`FB_REG_IRQ_EN, 2); // mask the write interrupt
		s0 = filled_cnt;
		hold[1] = 1'b0;
		t = 0;
		while (!rd_irq)
			tick(t, "read interrupt");
		t = 0;
		while (filled_cnt == s0)
			tick(t, "masked filled pulse");
		@(negedge clk);
		apb_read_check("irq_sts_both", `FB_REG_IRQ_STS, 3);
		check("irq_wt_masked", 0, 64'(wt_irq));
		apb_write(`FB_REG_CTRL, 0);
		apb_write(`FB_REG_IRQ_EN, 0);
		drain();
	endtask

	task automatic test_backpressure();
		stall = 1'b1;
		s0 = s2mm_log.size();
		m0 = mm2s_log.size();
		apb_write(`FB_REG_NSUB1, 3);
		apb_write(`FB_REG_CTRL, 1);
		t = 0;
		while (s2mm_log.size() < s0 + 6 || mm2s_log.size() < m0 + 6)
			tick(t, "commands under back-pressure");
		apb_write(`FB_REG_CTRL, 0);
		stall = 1'b0;
		drain();
	endtask

	initial begin
		paddr = '0;
		pwdata = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		lfsr = 32'hb28a2e78;
		stall = 1'b0;
		errors = 0;
		filled_cnt = 0;
		fetched_cnt = 0;
		for (int c = 0; c < 2; c++) begin
			rdy[c] = 1'b0;
			done[c] = 1'b0;
			hold[c] = 1'b0;
			out[c] = 1'b0;
			start[c] = 1'b0;
			held[c] = 1'b0;
			cnt[c] = -1;
		end
		t = 0;
		while (reset !== 1'b0)
			tick(t, "reset release");
		check("reset_valid", 0, 64'({vld[0], vld[1]}));
		check("reset_irq", 0, 64'({wt_irq, rd_irq}));
		test_regs();
		test_write_ring();
		test_proc_gate();
		test_pass_through();
		test_irq();
		test_backpressure();
		$display("%0d errors, %0d filled, %0d fetched", errors, filled_cnt, fetched_cnt);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/fb_pkg.sv
design/fb_ifs.sv
design/fb_reg_decode.sv
design/fb_slot_ctrl.sv
design/fb_cmd_issue.sv
design/frame_buffer_top.sv
tests/tb_clock_gen.sv
tests/tb_frame_buffer.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_frame_buffer -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
exit 0
